//--- common/tmr_config.svh
`ifndef TMR_CONFIG_SVH
`define TMR_CONFIG_SVH

//----------------------------------------------------------
// Widths
//----------------------------------------------------------
`define TMR_W          16                 // Counter and bus data width
`define TMR_PRS_W      8                  // Prescale value width
`define TMR_ADDR_W     4                  // Register address width

`define TMR_MAX        16'hFFFF           // Counter wraps here

// Fixed limit codes pick an all-ones value of (code + offset) bits
`define TMR_LIM_OFS    5                  // Code 3 gives 8 bits

//----------------------------------------------------------
// Register map
//----------------------------------------------------------
`define TMR_ADDR_CTRL  4'd1               // Control
`define TMR_ADDR_CFG   4'd2               // Prescale, TOP and compare select
`define TMR_ADDR_CNT   4'd3               // Live count
`define TMR_ADDR_OCR   4'd4               // Output compare
`define TMR_ADDR_STAT  4'd6               // Status flags

`endif

//--- common/tmr_pkg.sv
`include "tmr_config.svh"

package tmr_pkg;

	typedef enum logic [1:0] {
		MODE_NORMAL  = 2'd0,              // Free run, overflow at MAX
		MODE_CMP_CLR = 2'd1,              // Clear on TOP, pin toggles
		MODE_RSV     = 2'd2,              // Unused, acts as normal
		MODE_PWM     = 2'd3               // Clear on TOP, pin below compare
	} tmr_mode_e;

	typedef enum logic [3:0] {
		LIM_MAX   = 4'd0,                 // 0xFFFF
		LIM_OCR   = 4'd1,                 // Output compare register
		LIM_RSV   = 4'd2,                 // Unused, falls back to MAX
		LIM_BIT08 = 4'd3,                 // 0x00FF
		LIM_BIT09 = 4'd4,
		LIM_BIT10 = 4'd5,
		LIM_BIT11 = 4'd6,
		LIM_BIT12 = 4'd7,
		LIM_BIT13 = 4'd8,
		LIM_BIT14 = 4'd9,
		LIM_BIT15 = 4'd10                 // 0x7FFF
	} tmr_lim_e;

	// Control register, bit 0 at the bottom
	typedef struct packed {
		logic [2:0] pad;                  // [15:13]
		logic       single;               // [12] Stop after one period
		logic       pin_pol;              // [11] Invert output pin
		logic       pin_en;               // [10]
		tmr_mode_e  mode;                 // [9:8] Waveform mode
		logic       rsv7;                 // [7]
		logic       cnt_en;               // [6] Counting enable
		logic       rsv_cap;              // [5]
		logic       pwm_ie;               // [4]
		logic       cmp_ie;               // [3]
		logic       ovf_ie;               // [2]
		logic       int_en;               // [1] Global interrupt enable
		logic       glb_en;               // [0]
	} tmr_ctrl_t;

	typedef struct packed {
		tmr_lim_e              cmp_sel;   // [15:12] PWM compare source
		tmr_lim_e              top_sel;   // [11:8] TOP source
		logic [`TMR_PRS_W-1:0] prescale;  // [7:0]
	} tmr_cfg_t;

	typedef struct packed {
		logic ovf;                        // Count left MAX
		logic cmp;                        // Count left TOP
		logic pwm;                        // Count left compare value
	} tmr_evt_t;

	typedef struct packed {
		logic [10:0] pad;                 // [15:5]
		logic        single_done;         // [4] Period over, run held off
		logic        rsv_cap;             // [3] Always 0
		logic        pwm;                 // [2]
		logic        cmp;                 // [1]
		logic        ovf;                 // [0]
	} tmr_stat_t;

endpackage

//--- rtl/tmr_prescaler.sv
`timescale 1ns/1ps
`include "tmr_config.svh"

module tmr_prescaler
	import tmr_pkg::*;
(
	input  logic                  i_sysclk,
	input  logic                  i_sysrst,
	input  logic                  i_run,        // Divider advances
	input  logic                  i_ld,         // Take new prescale, restart
	input  logic [`TMR_PRS_W-1:0] i_prs,        // Divide by i_prs + 1
	output logic                  o_tick        // One-cycle count step
);

	logic [`TMR_PRS_W-1:0] prs_r;             // Active prescale value
	logic [`TMR_PRS_W-1:0] div_r;             // Cycles since last tick
	logic                  div_end;

	assign div_end = (div_r == prs_r);

	//----------------------------------------------------------
	// Divider
	//----------------------------------------------------------
	always_ff @(posedge i_sysclk)
	begin
		if (i_sysrst)
		begin
			prs_r <= '0;
			div_r <= '0;
		end
		else if (i_ld)
		begin
			prs_r <= i_prs;
			div_r <= '0;                          // Start a fresh period
		end
		else if (i_run)
		begin
			if (div_end)
				div_r <= '0;                      // Wrap with the tick
			else
				div_r <= div_r + 1'b1;
		end
	end

	// No tick while stopped or reloading
	assign o_tick = i_run & ~i_ld & div_end;

endmodule

//--- rtl/tmr_counter.sv
`timescale 1ns/1ps
`include "tmr_config.svh"

module tmr_counter
	import tmr_pkg::*;
(
	input  logic              i_sysclk,
	input  logic              i_sysrst,
	input  logic              i_tick,       // Step enable
	input  logic              i_ld,         // Bus load, highest priority
	input  logic [`TMR_W-1:0] i_ld_val,
	input  logic              i_clr,        // TOP match, acts on a tick
	output logic [`TMR_W-1:0] o_cnt
);

	logic [`TMR_W-1:0] cnt_r;
	logic              step;

	assign step = i_tick & ~i_ld;           // Tick under a load is lost

	//----------------------------------------------------------
	// Count register
	//----------------------------------------------------------
	always_ff @(posedge i_sysclk)
	begin
		if (i_sysrst)
			cnt_r <= '0;
		else if (i_ld)
			cnt_r <= i_ld_val;              // Software load
		else if (step)
		begin
			if (i_clr)
				cnt_r <= '0;                // Back to bottom at TOP
			else
				cnt_r <= cnt_r + 1'b1;      // MAX rolls to 0
		end
	end

	assign o_cnt = cnt_r;

endmodule

//--- rtl/tmr_waveform.sv
`timescale 1ns/1ps
`include "tmr_config.svh"

module tmr_waveform
	import tmr_pkg::*;
(
	input  logic              i_sysclk,
	input  logic              i_sysrst,
	input  tmr_ctrl_t         i_ctrl,       // Mode and pin settings
	input  tmr_cfg_t          i_cfg,        // TOP and compare sources
	input  logic [`TMR_W-1:0] i_ocr,
	input  logic [`TMR_W-1:0] i_cnt,
	input  logic              i_tick,
	output logic              o_clr,        // Counter clear at TOP
	output tmr_evt_t          o_evt,
	output logic              o_out_pin
);

	logic [`TMR_W-1:0] top_r;               // Count limit
	logic [`TMR_W-1:0] cmp_r;               // PWM compare value
	logic              pin_r;
	logic              clr_mode;            // Modes that clear at TOP
	logic              top_hit;
	logic              is_pwm;

	// Limit value for a source code
	function automatic logic [`TMR_W-1:0] lim_sel(input tmr_lim_e sel,
		input logic [`TMR_W-1:0] ocr);
		logic [4:0] shamt;
		shamt = 5'(`TMR_W - `TMR_LIM_OFS) - 5'(sel);
		case (sel)
			LIM_OCR                            : return ocr;
			LIM_BIT08, LIM_BIT09, LIM_BIT10,
			LIM_BIT11, LIM_BIT12, LIM_BIT13,
			LIM_BIT14, LIM_BIT15               : return `TMR_MAX >> shamt;
			LIM_MAX, LIM_RSV                   : return `TMR_MAX;
			default                            : return `TMR_MAX;   // Codes 11 to 15
		endcase
	endfunction

	always_ff @(posedge i_sysclk)
	begin
		if (i_sysrst)
		begin
			top_r <= `TMR_MAX;
			cmp_r <= `TMR_MAX;
		end
		else
		begin
			top_r <= lim_sel(i_cfg.top_sel, i_ocr);
			cmp_r <= lim_sel(i_cfg.cmp_sel, i_ocr);
		end
	end

	//----------------------------------------------------------
	// Matches and events, valid on tick cycles only
	//----------------------------------------------------------
	assign is_pwm   = (i_ctrl.mode == MODE_PWM);
	assign clr_mode = (i_ctrl.mode == MODE_CMP_CLR) | is_pwm;
	assign top_hit  = i_tick & clr_mode & (i_cnt == top_r);

	assign o_clr     = top_hit;
	assign o_evt.ovf = i_tick & (i_cnt == `TMR_MAX);
	assign o_evt.cmp = top_hit;
	assign o_evt.pwm = i_tick & is_pwm & (i_cnt == cmp_r);

	// Pin register
	always_ff @(posedge i_sysclk)
	begin
		if (i_sysrst)
			pin_r <= 1'b0;
		else if (!i_ctrl.pin_en)
			pin_r <= 1'b0;                  // Held low while pin is off
		else
		begin
			case (i_ctrl.mode)
				MODE_CMP_CLR : if (top_hit) pin_r <= ~pin_r;   // Half period per TOP
				MODE_PWM     : pin_r <= (i_cnt < cmp_r);       // High below compare
				MODE_NORMAL,
				MODE_RSV     : pin_r <= 1'b0;
				default      : pin_r <= 1'b0;
			endcase
		end
	end

	assign o_out_pin = (pin_r & i_ctrl.pin_en) ^ i_ctrl.pin_pol;

endmodule

//--- regs/tmr_regs.sv
`timescale 1ns/1ps
`include "tmr_config.svh"

module tmr_regs
	import tmr_pkg::*;
(
	input  logic                   i_sysclk,
	input  logic                   i_sysrst,
	input  logic                   i_bus_sel,     // Request this cycle
	input  logic                   i_bus_wr,
	input  logic [`TMR_ADDR_W-1:0] i_bus_addr,
	input  logic [`TMR_W-1:0]      i_bus_wdata,
	input  logic [`TMR_W-1:0]      i_cnt,         // Count for reads
	input  tmr_evt_t               i_evt,         // Events from waveform unit
	output logic [`TMR_W-1:0]      o_bus_rdata,
	output logic                   o_bus_ack,
	output logic                   o_int_flg,
	output tmr_ctrl_t              o_ctrl,
	output tmr_cfg_t               o_cfg,
	output logic [`TMR_W-1:0]      o_ocr,
	output logic                   o_run,         // Prescaler and counter run
	output logic                   o_prs_ld,      // One cycle after CFG write
	output logic                   o_cnt_ld,      // One cycle after CNT write
	output logic [`TMR_W-1:0]      o_cnt_ld_val
);

	tmr_ctrl_t          ctrl_r;
	tmr_cfg_t           cfg_r;
	tmr_stat_t          stat_r;
	tmr_stat_t          stat_nxt;
	tmr_ctrl_t          wdata_ctrl;                // Write data seen as CTRL
	tmr_stat_t          wdata_stat;                // Write data seen as STAT
	logic [`TMR_W-1:0]  ocr_r;
	logic [`TMR_W-1:0]  rd_mux;
	logic [`TMR_W-1:0]  rdata_r;
	logic [`TMR_W-1:0]  cnt_ld_val_r;
	logic               ack_r;
	logic               int_r;
	logic               prs_ld_r;
	logic               cnt_ld_r;
	logic               addr_ok;                   // Address maps to a register
	logic               req_wr;
	logic               wr_ctrl;
	logic               wr_cfg;
	logic               wr_cnt;
	logic               wr_ocr;
	logic               wr_stat;
	logic               int_en_nxt;

	assign wdata_ctrl = tmr_ctrl_t'(i_bus_wdata);
	assign wdata_stat = tmr_stat_t'(i_bus_wdata);

	//----------------------------------------------------------
	// Request decode
	//----------------------------------------------------------
	assign req_wr  = i_bus_sel & i_bus_wr;
	assign wr_ctrl = req_wr & (i_bus_addr == `TMR_ADDR_CTRL);
	assign wr_cfg  = req_wr & (i_bus_addr == `TMR_ADDR_CFG);
	assign wr_cnt  = req_wr & (i_bus_addr == `TMR_ADDR_CNT);
	assign wr_ocr  = req_wr & (i_bus_addr == `TMR_ADDR_OCR);
	assign wr_stat = req_wr & (i_bus_addr == `TMR_ADDR_STAT);

	always_comb
	begin
		addr_ok = 1'b1;
		rd_mux  = '0;                                // Invalid reads return 0
		case (i_bus_addr)
			`TMR_ADDR_CTRL : rd_mux = ctrl_r;
			`TMR_ADDR_CFG  : rd_mux = cfg_r;
			`TMR_ADDR_CNT  : rd_mux = i_cnt;         // Sampled at request
			`TMR_ADDR_OCR  : rd_mux = ocr_r;
			`TMR_ADDR_STAT : rd_mux = stat_r;
			default        : addr_ok = 1'b0;         // Capture address included
		endcase
	end

	//----------------------------------------------------------
	// Status flags
	//----------------------------------------------------------
	always_comb
	begin
		stat_nxt = stat_r;
		if (wr_stat)                                 // Bus write wins over events
		begin
			stat_nxt         = wdata_stat;
			stat_nxt.rsv_cap = 1'b0;
			stat_nxt.pad     = '0;
		end
		else
		begin
			stat_nxt.ovf = stat_r.ovf | (i_evt.ovf & ctrl_r.int_en & ctrl_r.ovf_ie);
			stat_nxt.cmp = stat_r.cmp | (i_evt.cmp & ctrl_r.int_en & ctrl_r.cmp_ie);
			stat_nxt.pwm = stat_r.pwm | (i_evt.pwm & ctrl_r.int_en & ctrl_r.pwm_ie);
			stat_nxt.single_done = stat_r.single_done
				| (ctrl_r.single & (i_evt.ovf | i_evt.cmp));   // End of one period
		end
	end

	// Flag follows the enable as it will be after this edge
	assign int_en_nxt = wr_ctrl ? wdata_ctrl.int_en : ctrl_r.int_en;

	//----------------------------------------------------------
	// Registers
	//----------------------------------------------------------
	always_ff @(posedge i_sysclk)
	begin
		if (i_sysrst)
		begin
			ctrl_r   <= '0;
			cfg_r    <= '0;
			ocr_r    <= '0;
			stat_r   <= '0;
			rdata_r  <= '0;
			ack_r    <= 1'b0;
			int_r    <= 1'b0;
			prs_ld_r <= 1'b0;
			cnt_ld_r <= 1'b0;
		end
		else
		begin
			stat_r   <= stat_nxt;
			int_r    <= int_en_nxt & (|stat_nxt[3:0]);
			ack_r    <= i_bus_sel & addr_ok;         // No ack on bad address
			rdata_r  <= (i_bus_sel & ~i_bus_wr) ? rd_mux : '0;
			prs_ld_r <= wr_cfg;                      // Prescaler restart
			cnt_ld_r <= wr_cnt;                      // Counter load
			if (wr_ctrl)
				ctrl_r <= wdata_ctrl;
			if (wr_cfg)
				cfg_r <= tmr_cfg_t'(i_bus_wdata);
			if (wr_ocr)
				ocr_r <= i_bus_wdata;
		end
	end

	always_ff @(posedge i_sysclk)
	begin
		if (wr_cnt)
			cnt_ld_val_r <= i_bus_wdata;             // Value for the load pulse
	end

	assign o_bus_rdata  = rdata_r;
	assign o_bus_ack    = ack_r;
	assign o_int_flg    = int_r;
	assign o_ctrl       = ctrl_r;
	assign o_cfg        = cfg_r;
	assign o_ocr        = ocr_r;
	assign o_prs_ld     = prs_ld_r;
	assign o_cnt_ld     = cnt_ld_r;
	assign o_cnt_ld_val = cnt_ld_val_r;
	assign o_run        = ctrl_r.glb_en & ctrl_r.cnt_en & ~stat_r.single_done;

endmodule

//--- rtl/tmr_top.sv
`timescale 1ns/1ps
`include "tmr_config.svh"

module tmr_top
	import tmr_pkg::*;
(
	input  logic                   i_sysclk,     // System clock
	input  logic                   i_sysrst,     // Sync reset, active high
	input  logic                   i_bus_sel,    // Peripheral select
	input  logic                   i_bus_wr,     // 1 write, 0 read
	input  logic [`TMR_ADDR_W-1:0] i_bus_addr,   // Register address
	input  logic [`TMR_W-1:0]      i_bus_wdata,  // Write data
	output logic [`TMR_W-1:0]      o_bus_rdata,  // Read data, one cycle later
	output logic                   o_bus_ack,    // Valid address response
	output logic                   o_int_flg,    // Any status flag pending
	output logic                   o_out_pin     // Waveform output
);

	//----------------------------------------------------------
	// Internal nets
	//----------------------------------------------------------
	tmr_ctrl_t          ctrl;                    // Control fields
	tmr_cfg_t           cfg;                     // Prescale and limit sources
	tmr_evt_t           evt;                     // Event pulses to status
	logic [`TMR_W-1:0]  ocr;
	logic [`TMR_W-1:0]  cnt;                     // Live count
	logic [`TMR_W-1:0]  cnt_ld_val;
	logic               run;                     // Counting allowed
	logic               prs_ld;                  // Prescaler reload
	logic               cnt_ld;                  // Counter load
	logic               tick;                    // Count step
	logic               clr;                     // TOP match clear

	tmr_regs u_regs (
		.i_sysclk     (i_sysclk),
		.i_sysrst     (i_sysrst),
		.i_bus_sel    (i_bus_sel),
		.i_bus_wr     (i_bus_wr),
		.i_bus_addr   (i_bus_addr),
		.i_bus_wdata  (i_bus_wdata),
		.i_cnt        (cnt),
		.i_evt        (evt),
		.o_bus_rdata  (o_bus_rdata),
		.o_bus_ack    (o_bus_ack),
		.o_int_flg    (o_int_flg),
		.o_ctrl       (ctrl),
		.o_cfg        (cfg),
		.o_ocr        (ocr),
		.o_run        (run),
		.o_prs_ld     (prs_ld),
		.o_cnt_ld     (cnt_ld),
		.o_cnt_ld_val (cnt_ld_val)
	);

	tmr_prescaler u_prescaler (
		.i_sysclk (i_sysclk),
		.i_sysrst (i_sysrst),
		.i_run    (run),
		.i_ld     (prs_ld),
		.i_prs    (cfg.prescale),
		.o_tick   (tick)
	);

	tmr_counter u_counter (
		.i_sysclk (i_sysclk),
		.i_sysrst (i_sysrst),
		.i_tick   (tick),
		.i_ld     (cnt_ld),
		.i_ld_val (cnt_ld_val),
		.i_clr    (clr),
		.o_cnt    (cnt)
	);

	tmr_waveform u_waveform (
		.i_sysclk  (i_sysclk),
		.i_sysrst  (i_sysrst),
		.i_ctrl    (ctrl),
		.i_cfg     (cfg),
		.i_ocr     (ocr),
		.i_cnt     (cnt),
		.i_tick    (tick),
		.o_clr     (clr),
		.o_evt     (evt),
		.o_out_pin (o_out_pin)
	);

endmodule

//--- tests/tmr_chk.sv
`timescale 1ns/1ps
`include "tmr_config.svh"

module tmr_chk
	import tmr_pkg::*;
(
	input logic              i_sysclk,
	input logic              i_sysrst,
	input logic              i_bus_sel,
	input logic              i_bus_ack,     // DUT acknowledge
	input logic              i_int_flg,     // DUT interrupt flag
	input tmr_ctrl_t         i_ctrl,
	input logic              i_run,
	input logic              i_cnt_ld,      // Counter load pulse
	input logic [`TMR_W-1:0] i_cnt          // Live count
);

	int fail_cnt = 0;                       // Assertion failures seen

	// Second ack in a row needs its own request
	a_ack_req : assert property (@(posedge i_sysclk) disable iff (i_sysrst)
		(i_bus_ack && $past(i_bus_ack)) |-> $past(i_bus_sel))
	else
	begin
		fail_cnt++;
		$error("bus acknowledge high two cycles without a request");
	end

	a_int_gate : assert property (@(posedge i_sysclk) disable iff (i_sysrst)
		!i_ctrl.int_en |-> !i_int_flg)
	else
	begin
		fail_cnt++;
		$error("interrupt flag high with interrupts disabled");
	end

	// Stopped timer moves only by a bus load, never by a tick or clear
	a_stop_hold : assert property (@(posedge i_sysclk) disable iff (i_sysrst)
		(!i_run && !i_cnt_ld) |=> $stable(i_cnt))
	else
	begin
		fail_cnt++;
		$error("count changed while run and load were low");
	end

endmodule

bind tmr_top tmr_chk u_chk (
	.i_sysclk  (i_sysclk),
	.i_sysrst  (i_sysrst),
	.i_bus_sel (i_bus_sel),
	.i_bus_ack (o_bus_ack),
	.i_int_flg (o_int_flg),
	.i_ctrl    (ctrl),
	.i_run     (run),
	.i_cnt_ld  (cnt_ld),
	.i_cnt     (cnt)
);

//--- tests/tmr_tb.sv
`timescale 1ns/1ps
`include "tmr_config.svh"

module tmr_tb;

	localparam int ACK_TO  = 4;                 // Cycles allowed for a bus response
	localparam int WAIT_TO = 200;               // Cycles or polls allowed for a change

	// Control register bits
	localparam logic [15:0] C_GLB    = 16'h0001;
	localparam logic [15:0] C_INT    = 16'h0002;
	localparam logic [15:0] C_OVF_IE = 16'h0004;
	localparam logic [15:0] C_CNT_EN = 16'h0040;
	localparam logic [15:0] C_CMPCLR = 16'h0100; // Mode 1
	localparam logic [15:0] C_PWM    = 16'h0300; // Mode 3
	localparam logic [15:0] C_PIN_EN = 16'h0400;
	localparam logic [15:0] C_POL    = 16'h0800;
	localparam logic [15:0] C_SINGLE = 16'h1000;

	logic                   i_sysclk;
	logic                   i_sysrst;
	logic                   i_bus_sel;
	logic                   i_bus_wr;
	logic [`TMR_ADDR_W-1:0] i_bus_addr;
	logic [`TMR_W-1:0]      i_bus_wdata;
	logic [`TMR_W-1:0]      o_bus_rdata;
	logic                   o_bus_ack;
	logic                   o_int_flg;
	logic                   o_out_pin;
	int                     chk_cnt;            // Checks run
	int                     err_cnt;            // Wrong values and missing acks
	int                     to_cnt;             // Timeouts

	tmr_top u_dut (
		.i_sysclk    (i_sysclk),
		.i_sysrst    (i_sysrst),
		.i_bus_sel   (i_bus_sel),
		.i_bus_wr    (i_bus_wr),
		.i_bus_addr  (i_bus_addr),
		.i_bus_wdata (i_bus_wdata),
		.o_bus_rdata (o_bus_rdata),
		.o_bus_ack   (o_bus_ack),
		.o_int_flg   (o_int_flg),
		.o_out_pin   (o_out_pin)
	);

	always #4 i_sysclk = ~i_sysclk;             // 8 ns period

	//----------------------------------------------------------
	// Timing and checks
	//----------------------------------------------------------
	task automatic next_cycle();
		@(posedge i_sysclk);
		#1;                                     // Drive and sample off the edge
	endtask

	task automatic idle(input int n);
		for (int i = 0; i < n; i++)
			next_cycle();
	endtask

	task automatic apply_reset();
		i_sysrst    = 1'b1;
		i_bus_sel   = 1'b0;
		i_bus_wr    = 1'b0;
		i_bus_addr  = '0;
		i_bus_wdata = '0;
		idle(2);                                // Two reset cycles
		i_sysrst    = 1'b0;
	endtask

	task automatic expect_eq(input string name, input logic [15:0] got, input logic [15:0] exp);
		chk_cnt++;
		assert (got === exp)
		else
		begin
			err_cnt++;
			$display("[ERROR] %0t ns %s: got 0x%04h, expected 0x%04h", $time, name, got, exp);
		end
	endtask

	task automatic expect_range(input string name, input int got, input int lo, input int hi);
		chk_cnt++;
		assert (got >= lo && got <= hi)
		else
		begin
			err_cnt++;
			$display("[ERROR] %0t ns %s: got %0d, expected %0d to %0d", $time, name, got, lo, hi);
		end
	endtask

	//----------------------------------------------------------
	// Bus access
	//----------------------------------------------------------
	task automatic bus_req(input logic wr, input logic [3:0] addr, input logic [15:0] wdata,
		output logic [15:0] rdata, output logic ack);
		int n;
		i_bus_sel   = 1'b1;
		i_bus_wr    = wr;
		i_bus_addr  = addr;
		i_bus_wdata = wdata;
		next_cycle();                           // Request taken at this edge
		i_bus_sel   = 1'b0;
		i_bus_wr    = 1'b0;
		rdata       = o_bus_rdata;              // Response cycle data
		ack         = 1'b0;
		n           = 0;
		while (!ack && n < ACK_TO)
		begin
			if (o_bus_ack)
			begin
				ack   = 1'b1;
				rdata = o_bus_rdata;
			end
			else
			begin
				next_cycle();
				n++;
			end
		end
	endtask

	task automatic bus_write(input logic [3:0] addr, input logic [15:0] data);
		logic [15:0] rd;
		logic        ack;
		bus_req(1'b1, addr, data, rd, ack);
		chk_cnt++;
		assert (ack)
		else
		begin
			err_cnt++;
			$display("%0t ns: write to address %0d got no acknowledge", $time, addr);
		end
		expect_eq("o_bus_rdata", rd, 16'h0000);  // Writes return 0
	endtask

	task automatic bus_read(input logic [3:0] addr, output logic [15:0] data);
		logic ack;
		bus_req(1'b0, addr, 16'h0000, data, ack);
		chk_cnt++;
		assert (ack)
		else
		begin
			err_cnt++;
			$display("%0t ns: read of address %0d got no acknowledge", $time, addr);
		end
	endtask

	task automatic await_int(input logic level);
		int n;
		n = 0;
		while (o_int_flg !== level && n < WAIT_TO)
		begin
			next_cycle();
			n++;
		end
		chk_cnt++;
		assert (o_int_flg === level)
		else
		begin
			to_cnt++;
			$display("%0t ns: timed out waiting for o_int_flg to become %0b", $time, level);
		end
	endtask

	task automatic await_pin(input logic level);
		int n;
		n = 0;
		while (o_out_pin !== level && n < WAIT_TO)
		begin
			next_cycle();
			n++;
		end
		expect_eq("o_out_pin", {15'd0, o_out_pin}, {15'd0, level});
	endtask

	//----------------------------------------------------------
	// Directed tests
	//----------------------------------------------------------
	task automatic regs_readback();
		logic [15:0] v_ctrl;
		logic [15:0] v_cfg;
		logic [15:0] v_ocr;
		logic [15:0] rd;
		logic        ack;
		apply_reset();
		v_ctrl = 16'($urandom);
		v_cfg  = 16'($urandom);
		v_ocr  = 16'($urandom);
		bus_write(`TMR_ADDR_CTRL, v_ctrl);
		bus_write(`TMR_ADDR_CFG, v_cfg);
		bus_write(`TMR_ADDR_OCR, v_ocr);
		bus_read(`TMR_ADDR_CTRL, rd);
		expect_eq("CTRL", rd, v_ctrl);
		bus_read(`TMR_ADDR_CFG, rd);
		expect_eq("CFG", rd, v_cfg);
		bus_read(`TMR_ADDR_OCR, rd);
		expect_eq("OCR", rd, v_ocr);
		for (int a = 0; a < 16; a++)
		begin
			if (a == 0 || a == 5 || a >= 7)      // Unmapped, capture slot too
			begin
				bus_req(1'b0, 4'(a), 16'h0000, rd, ack);
				expect_eq("o_bus_ack", {15'd0, ack}, 16'h0000);
				expect_eq("o_bus_rdata", rd, 16'h0000);
			end
		end
	endtask

	task automatic overflow_irq();
		logic [15:0] rd;
		apply_reset();
		bus_write(`TMR_ADDR_CFG, 16'h0000);     // Prescale 0, limits at MAX
		bus_write(`TMR_ADDR_CNT, 16'hFFF0);     // 16 ticks short of overflow
		bus_write(`TMR_ADDR_CTRL, C_GLB | C_INT | C_OVF_IE | C_CNT_EN);
		await_int(1'b1);
		bus_read(`TMR_ADDR_STAT, rd);
		expect_eq("STAT", rd, 16'h0001);        // Only ovf set
		bus_write(`TMR_ADDR_STAT, 16'h0000);
		await_int(1'b0);
	endtask

	task automatic compare_clear();
		logic [15:0] rd;
		logic        prev;
		int          toggles;
		apply_reset();
		bus_write(`TMR_ADDR_OCR, 16'd9);
		bus_write(`TMR_ADDR_CFG, 16'h0101);     // TOP from OCR, prescale 1
		bus_write(`TMR_ADDR_CTRL, C_GLB | C_CNT_EN | C_CMPCLR | C_PIN_EN);
		for (int i = 0; i < 30; i++)
		begin
			bus_read(`TMR_ADDR_CNT, rd);
			expect_range("count", int'(rd), 0, 9);
		end
		prev    = o_out_pin;
		toggles = 0;
		for (int i = 0; i < 400; i++)
		begin
			next_cycle();
			if (o_out_pin !== prev)
				toggles++;
			prev = o_out_pin;
		end
		expect_range("pin toggles", toggles, 19, 21);   // 10 counts of 2 cycles each
	endtask

	task automatic pwm_pin();
		apply_reset();
		bus_write(`TMR_ADDR_CFG, 16'h3000);     // Compare value 0x00FF
		bus_write(`TMR_ADDR_CTRL, C_GLB | C_PWM | C_PIN_EN);
		bus_write(`TMR_ADDR_CNT, 16'h0200);
		await_pin(1'b0);                        // Above compare
		bus_write(`TMR_ADDR_CNT, 16'h0010);
		await_pin(1'b1);                        // Below compare
		bus_write(`TMR_ADDR_CTRL, C_GLB | C_PWM | C_PIN_EN | C_POL);
		await_pin(1'b0);
		bus_write(`TMR_ADDR_CNT, 16'h0200);
		await_pin(1'b1);
	endtask

	task automatic single_period();
		logic [15:0] rd;
		logic [15:0] c1;
		logic [15:0] c2;
		logic        moved;
		int          n;
		apply_reset();
		bus_write(`TMR_ADDR_OCR, 16'd9);
		bus_write(`TMR_ADDR_CFG, 16'h0100);     // TOP from OCR, prescale 0
		bus_write(`TMR_ADDR_CTRL, C_GLB | C_CNT_EN | C_CMPCLR | C_SINGLE);
		n  = 0;
		rd = '0;
		while (!rd[4] && n < WAIT_TO)           // Poll for single_done
		begin
			bus_read(`TMR_ADDR_STAT, rd);
			n++;
		end
		expect_eq("STAT", rd, 16'h0010);
		bus_read(`TMR_ADDR_CNT, c1);
		idle(19);                               // Samples 20 cycles apart
		bus_read(`TMR_ADDR_CNT, c2);
		expect_eq("count", c2, c1);             // Held while stopped
		bus_write(`TMR_ADDR_STAT, 16'h0000);
		n     = 0;
		moved = 1'b0;
		while (!moved && n < 20)
		begin
			bus_read(`TMR_ADDR_CNT, c2);
			moved = (c2 !== c1);
			n++;
		end
		chk_cnt++;
		assert (moved)
		else
		begin
			to_cnt++;
			$display("%0t ns: count did not advance after single_done was cleared", $time);
		end
	endtask

	task automatic prescale_rate();
		logic [15:0] c1;
		logic [15:0] c2;
		apply_reset();
		bus_write(`TMR_ADDR_CFG, 16'h0003);     // One tick every 4 cycles
		bus_write(`TMR_ADDR_CTRL, C_GLB | C_CNT_EN);
		bus_read(`TMR_ADDR_CNT, c1);
		idle(79);                               // 80 cycles between samples
		bus_read(`TMR_ADDR_CNT, c2);
		expect_range("count step", int'(c2) - int'(c1), 19, 21);
	endtask

	initial
	begin
		i_sysclk    = 1'b0;
		i_sysrst    = 1'b1;
		i_bus_sel   = 1'b0;
		i_bus_wr    = 1'b0;
		i_bus_addr  = '0;
		i_bus_wdata = '0;
		chk_cnt     = 0;
		err_cnt     = 0;
		to_cnt      = 0;
		void'($urandom(90891));
		regs_readback();
		overflow_irq();
		compare_clear();
		pwm_pin();
		single_period();
		prescale_rate();
		$display("Checks: %0d, errors: %0d, timeouts: %0d, assertion failures: %0d",
			chk_cnt, err_cnt, to_cnt, u_dut.u_chk.fail_cnt);
		if (err_cnt == 0 && to_cnt == 0 && u_dut.u_chk.fail_cnt == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- all.f
+incdir+common
common/tmr_pkg.sv
rtl/tmr_prescaler.sv
rtl/tmr_counter.sv
rtl/tmr_waveform.sv
regs/tmr_regs.sv
rtl/tmr_top.sv
tests/tmr_chk.sv
tests/tmr_tb.sv

//--- run.sh
#!/bin/sh
# Build the timer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tmr_tb -f all.f -o tmr_sim; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/tmr_sim 2>&1)
rc=$?
printf '%s\n' "$out"

if [ "$rc" -ne 0 ]; then
	echo "Simulation exited with status $rc"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx '=== PASS ==='; then
	exit 0
fi

echo "Pass message not found in simulation output"
exit 1
